// ==== vidPkg.sv ====
package vidPkg;

    // Raster coordinates
    typedef logic [10:0] hPos_t;  // Pixel clocks within a line
    typedef logic [9:0]  vPos_t;  // Lines within a frame

    // RGB565, red on top
    typedef logic [15:0] rgb565_t;

    typedef struct packed {
        hPos_t hPos;
        vPos_t vPos;
    } rasterPos_t;

    // Phase of one axis
    typedef enum logic [1:0] {
        ACTIVE = 2'd0,
        FRONT  = 2'd1,
        SYNC   = 2'd2,
        BACK   = 2'd3
    } vidPhase_e;

    typedef struct packed {
        logic hSync;
        logic vSync;
    } syncLevels_t;

    // Values presented on the DAC pins
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
        logic       nBlank;
    } dacPixel_t;

endpackage

// ==== vidRasterCounter.sv ====
`timescale 1ns/1ps

module vidRasterCounter
    import vidPkg::*;
#(
    parameter int HorAddrVideoTime  = 640,
    parameter int HorFrontPorch     = 16,
    parameter int HorSyncTime       = 96,
    parameter int HorBackPorch      = 48,
    parameter int VertAddrVideoTime = 480,
    parameter int VertFrontPorch    = 10,
    parameter int VertSyncTime      = 2,
    parameter int VertBackPorch     = 33
) (
    input  logic       i_VidClk,
    input  logic       i_arstN,
    output rasterPos_t o_pos,
    output logic       o_lineEnd,
    output logic       o_frameEnd
);

    localparam int LineLen  = HorAddrVideoTime + HorFrontPorch + HorSyncTime + HorBackPorch;
    localparam int FrameLen = VertAddrVideoTime + VertFrontPorch + VertSyncTime + VertBackPorch;

    localparam hPos_t HLast = hPos_t'(LineLen - 1);
    localparam vPos_t VLast = vPos_t'(FrameLen - 1);

    hPos_t hPos;
    vPos_t vPos;

    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            hPos <= '0;
            vPos <= '0;
        end else if (hPos == HLast) begin
            hPos <= '0;  // Wrap at end of line
            if (vPos == VLast) begin
                vPos <= '0;
            end else begin
                vPos <= vPos + vPos_t'(1);
            end
        end else begin
            hPos <= hPos + hPos_t'(1);
        end
    end

    assign o_pos      = '{hPos: hPos, vPos: vPos};
    assign o_lineEnd  = (hPos == HLast);
    assign o_frameEnd = o_lineEnd && (vPos == VLast);  // Last pixel of last line

    // Both counters stay inside the configured raster
    assert property (@(posedge i_VidClk) disable iff (!i_arstN)
        (int'(hPos) < LineLen) && (int'(vPos) < FrameLen))
    else $error("Raster position out of range h=%0d v=%0d", hPos, vPos);

endmodule

// ==== vidPhaseFsm.sv ====
`timescale 1ns/1ps

module vidPhaseFsm
    import vidPkg::*;
#(
    parameter int HorAddrVideoTime  = 640,
    parameter int HorFrontPorch     = 16,
    parameter int HorSyncTime       = 96,
    parameter int HorBackPorch      = 48,
    parameter int VertAddrVideoTime = 480,
    parameter int VertFrontPorch    = 10,
    parameter int VertSyncTime      = 2,
    parameter int VertBackPorch     = 33
) (
    input  logic        i_VidClk,
    input  logic        i_arstN,
    input  rasterPos_t  i_pos,
    input  logic        i_lineEnd,
    output logic        o_active,
    output logic        o_vBlank,
    output syncLevels_t o_sync
);

    localparam int LineLen  = HorAddrVideoTime + HorFrontPorch + HorSyncTime + HorBackPorch;
    localparam int FrameLen = VertAddrVideoTime + VertFrontPorch + VertSyncTime + VertBackPorch;

    // Last position of each phase, the state moves on the following edge
    localparam hPos_t HActLast   = hPos_t'(HorAddrVideoTime - 1);
    localparam hPos_t HFrontLast = hPos_t'(HorAddrVideoTime + HorFrontPorch - 1);
    localparam hPos_t HSyncLast  = hPos_t'(HorAddrVideoTime + HorFrontPorch + HorSyncTime - 1);
    localparam hPos_t HBackLast  = hPos_t'(LineLen - 1);
    localparam vPos_t VActLast   = vPos_t'(VertAddrVideoTime - 1);
    localparam vPos_t VFrontLast = vPos_t'(VertAddrVideoTime + VertFrontPorch - 1);
    localparam vPos_t VSyncLast  = vPos_t'(VertAddrVideoTime + VertFrontPorch + VertSyncTime - 1);
    localparam vPos_t VBackLast  = vPos_t'(FrameLen - 1);

    vidPhase_e hState, hNext;  // Phase of the current i_pos
    vidPhase_e vState, vNext;

    always_comb begin
        hNext = hState;
        case (hState)
            ACTIVE:  if (i_pos.hPos == HActLast)   hNext = FRONT;
            FRONT:   if (i_pos.hPos == HFrontLast) hNext = SYNC;
            SYNC:    if (i_pos.hPos == HSyncLast)  hNext = BACK;
            default: if (i_pos.hPos == HBackLast)  hNext = ACTIVE;
        endcase
    end

    // Vertical phase only moves at the end of a line
    always_comb begin
        vNext = vState;
        if (i_lineEnd) begin
            case (vState)
                ACTIVE:  if (i_pos.vPos == VActLast)   vNext = FRONT;
                FRONT:   if (i_pos.vPos == VFrontLast) vNext = SYNC;
                SYNC:    if (i_pos.vPos == VSyncLast)  vNext = BACK;
                default: if (i_pos.vPos == VBackLast)  vNext = ACTIVE;
            endcase
        end
    end

    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            hState   <= ACTIVE;  // Matches position (0,0)
            vState   <= ACTIVE;
            o_active <= 1'b0;
            o_vBlank <= 1'b0;
            o_sync   <= '0;
        end else begin
            hState       <= hNext;
            vState       <= vNext;
            o_active     <= (hState == ACTIVE) && (vState == ACTIVE);
            o_vBlank     <= (vState != ACTIVE);
            o_sync.hSync <= (hState == SYNC);
            o_sync.vSync <= (vState == SYNC);
        end
    end

    // No sync pulse while pixels are shown
    assert property (@(posedge i_VidClk) disable iff (!i_arstN)
        o_active |-> !(o_sync.hSync || o_sync.vSync))
    else $error("Sync asserted during active video");

    // A line starts only where the counter wrapped
    assert property (@(posedge i_VidClk) disable iff (!i_arstN)
        (hState == ACTIVE) && ($past(hState) != ACTIVE) |-> (i_pos.hPos == '0))
    else $error("Horizontal ACTIVE entered at h=%0d", i_pos.hPos);

endmodule

// ==== vidPatternSource.sv ====
`timescale 1ns/1ps

module vidPatternSource
    import vidPkg::*;
#(
    parameter int HorAddrVideoTime  = 640,
    parameter int VertAddrVideoTime = 480
) (
    input  logic       i_VidClk,
    input  logic       i_arstN,
    input  rasterPos_t i_pos,
    input  logic       i_patternEn,
    input  rgb565_t    i_colour,
    output rgb565_t    o_colour
);

    localparam hPos_t HLastCol = hPos_t'(HorAddrVideoTime - 1);
    localparam vPos_t VLastRow = vPos_t'(VertAddrVideoTime - 1);

    rgb565_t patNext;
    rgb565_t patColour;  // Pattern for the previous position
    logic    patSel;     // Mode seen with the previous position
    logic    onBorder;

    always_comb begin
        onBorder = (i_pos.hPos == '0) || (i_pos.hPos == HLastCol) ||
                   (i_pos.vPos == '0) || (i_pos.vPos == VLastRow);
        if (onBorder) begin
            patNext = 16'hFFFF;  // White frame
        end else begin
            patNext = {i_pos.hPos[4:0],
                       i_pos.vPos[5:0],
                       i_pos.hPos[4:0] ^ i_pos.vPos[4:0]};
        end
    end

    always_ff @(posedge i_VidClk) begin
        patColour <= patNext;
    end

    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            patSel <= 1'b0;
        end else begin
            patSel <= i_patternEn;
        end
    end

    // External colour already arrives one cycle after its position
    assign o_colour = patSel ? patColour : i_colour;

endmodule

// ==== vidDacOutput.sv ====
`timescale 1ns/1ps

module vidDacOutput
    import vidPkg::*;
(
    input  logic        i_VidClk,
    input  logic        i_arstN,
    input  logic        i_active,
    input  syncLevels_t i_sync,
    input  rgb565_t     i_colour,
    output dacPixel_t   o_pixel,
    output logic        o_hSync,
    output logic        o_vSync
);

    dacPixel_t pixelNext;

    always_comb begin
        if (i_active) begin
            pixelNext.red    = i_colour[15:11];
            pixelNext.green  = i_colour[10:5];
            pixelNext.blue   = i_colour[4:0];
            pixelNext.nBlank = 1'b1;
        end else begin
            pixelNext = '0;  // Blanked, DAC wants black
        end
    end

    // Colour, blank and sync leave on the same edge
    always_ff @(posedge i_VidClk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_pixel <= '0;
            o_hSync <= 1'b0;
            o_vSync <= 1'b0;
        end else begin
            o_pixel <= pixelNext;
            o_hSync <= i_sync.hSync;
            o_vSync <= i_sync.vSync;
        end
    end

    assert property (@(posedge i_VidClk) disable iff (!i_arstN)
        !o_pixel.nBlank |-> ({o_pixel.red, o_pixel.green, o_pixel.blue} == '0))
    else $error("Colour on DAC pins while blanked");

endmodule

// ==== adv7123Video.sv ====
`timescale 1ns/1ps

module adv7123Video
    import vidPkg::*;
#(
    parameter int HorAddrVideoTime  = 640,
    parameter int HorFrontPorch     = 16,
    parameter int HorSyncTime       = 96,
    parameter int HorBackPorch      = 48,
    parameter int VertAddrVideoTime = 480,
    parameter int VertFrontPorch    = 10,
    parameter int VertSyncTime      = 2,
    parameter int VertBackPorch     = 33
) (
    input  logic       i_VidClk,
    input  logic       i_arstN,
    input  logic       i_patternEn,
    input  rgb565_t    i_colour,
    output hPos_t      o_nextHPos,
    output vPos_t      o_nextVPos,
    output logic       o_inActiveArea,
    output logic       o_inVBlank,
    output logic       o_pixelClk,
    output logic       o_hSync,
    output logic       o_vSync,
    output logic       o_nBlank,
    output logic [4:0] o_r,
    output logic [5:0] o_g,
    output logic [4:0] o_b
);

    rasterPos_t  pos;
    logic        lineEnd;
    logic        active;
    syncLevels_t sync;
    rgb565_t     colour;
    dacPixel_t   pixel;

    vidRasterCounter #(
        .HorAddrVideoTime(HorAddrVideoTime), .HorFrontPorch(HorFrontPorch),
        .HorSyncTime(HorSyncTime), .HorBackPorch(HorBackPorch),
        .VertAddrVideoTime(VertAddrVideoTime), .VertFrontPorch(VertFrontPorch),
        .VertSyncTime(VertSyncTime), .VertBackPorch(VertBackPorch)
    ) u_counter (
        .i_VidClk(i_VidClk), .i_arstN(i_arstN),
        .o_pos(pos), .o_lineEnd(lineEnd), .o_frameEnd()
    );

    vidPhaseFsm #(
        .HorAddrVideoTime(HorAddrVideoTime), .HorFrontPorch(HorFrontPorch),
        .HorSyncTime(HorSyncTime), .HorBackPorch(HorBackPorch),
        .VertAddrVideoTime(VertAddrVideoTime), .VertFrontPorch(VertFrontPorch),
        .VertSyncTime(VertSyncTime), .VertBackPorch(VertBackPorch)
    ) u_phase (
        .i_VidClk(i_VidClk), .i_arstN(i_arstN), .i_pos(pos), .i_lineEnd(lineEnd),
        .o_active(active), .o_vBlank(o_inVBlank), .o_sync(sync)
    );

    vidPatternSource #(
        .HorAddrVideoTime(HorAddrVideoTime), .VertAddrVideoTime(VertAddrVideoTime)
    ) u_source (
        .i_VidClk(i_VidClk), .i_arstN(i_arstN), .i_pos(pos),
        .i_patternEn(i_patternEn), .i_colour(i_colour), .o_colour(colour)
    );

    vidDacOutput u_dac (
        .i_VidClk(i_VidClk), .i_arstN(i_arstN), .i_active(active), .i_sync(sync),
        .i_colour(colour), .o_pixel(pixel), .o_hSync(o_hSync), .o_vSync(o_vSync)
    );

    assign o_nextHPos     = pos.hPos;
    assign o_nextVPos     = pos.vPos;
    assign o_inActiveArea = active;
    assign o_pixelClk     = ~i_VidClk;  // DAC samples on the falling video edge
    assign o_nBlank       = pixel.nBlank;
    assign o_r            = pixel.red;
    assign o_g            = pixel.green;
    assign o_b            = pixel.blue;

endmodule

// ==== tb_vidClkGen.sv ====
`timescale 1ns/1ps

module tb_vidClkGen #(
    parameter int HalfPeriod  = 50,  // ns, gives a 100 ns video clock
    parameter int ResetCycles = 2
) (
    output logic o_VidClk,
    output logic o_arstN
);

    initial begin
        o_VidClk = 1'b0;
        forever #HalfPeriod o_VidClk = ~o_VidClk;
    end

    initial begin
        o_arstN = 1'b0;
        repeat (ResetCycles) @(posedge o_VidClk);
        o_arstN <= 1'b1;  // Released right after an edge
    end

endmodule

// ==== tb_adv7123Video.sv ====
`timescale 1ns/1ps

module tb_adv7123Video
    import vidPkg::*;
();

    localparam int HActive   = 16;
    localparam int HFront    = 2;
    localparam int HSyncLen  = 3;
    localparam int HBack     = 3;
    localparam int VActive   = 6;
    localparam int VFront    = 1;
    localparam int VSyncLen  = 2;
    localparam int VBack     = 2;
    localparam int LineLen   = HActive + HFront + HSyncLen + HBack;  // 24 clocks
    localparam int FrameLen  = VActive + VFront + VSyncLen + VBack;  // 11 lines
    localparam int TableSize = LineLen * FrameLen;
    localparam int FrameWait = TableSize + 4;

    typedef struct packed {
        logic    active;
        logic    vBlank;
        logic    hSync;
        logic    vSync;
        rgb565_t colour;
    } expOut_t;

    logic       vidClk;
    logic       arstN;
    logic       patternEn;
    rgb565_t    colourIn = '0;
    hPos_t      nextHPos;
    vPos_t      nextVPos;
    logic       inActiveArea;
    logic       inVBlank;
    logic       pixelClk;
    logic       hSyncPin;
    logic       vSyncPin;
    logic       nBlank;
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;

    rgb565_t extTable [TableSize];  // External source, one colour per position
    int      seed = 32'h78dc_4b08;
    int      colourIdx = 0;
    int      histH [2];  // [0] one cycle back, [1] two cycles back
    int      histV [2];
    logic    histMode [2];
    int      histValid = 0;
    int      expH = 0;
    int      expV = 0;
    int      errorCount = 0;
    int      timeoutCount = 0;
    bit      timedOut = 1'b0;

    tb_vidClkGen #(.HalfPeriod(50), .ResetCycles(2)) u_clkGen (
        .o_VidClk(vidClk),
        .o_arstN(arstN)
    );

    adv7123Video #(
        .HorAddrVideoTime(HActive), .HorFrontPorch(HFront),
        .HorSyncTime(HSyncLen), .HorBackPorch(HBack),
        .VertAddrVideoTime(VActive), .VertFrontPorch(VFront),
        .VertSyncTime(VSyncLen), .VertBackPorch(VBack)
    ) u_dut (
        .i_VidClk(vidClk), .i_arstN(arstN), .i_patternEn(patternEn), .i_colour(colourIn),
        .o_nextHPos(nextHPos), .o_nextVPos(nextVPos),
        .o_inActiveArea(inActiveArea), .o_inVBlank(inVBlank), .o_pixelClk(pixelClk),
        .o_hSync(hSyncPin), .o_vSync(vSyncPin), .o_nBlank(nBlank),
        .o_r(red), .o_g(green), .o_b(blue)
    );

    // White border on the outer active rows and columns, gradient inside
    function automatic rgb565_t patternColour(int h, int v);
        int r;
        int g;
        int b;
        if (h == 0 || h == HActive - 1 || v == 0 || v == VActive - 1) begin
            return 16'hFFFF;
        end
        r = h % 32;  // Red ramps along the line
        g = v % 64;  // Green ramps down the frame
        b = (h ^ v) % 32;
        return rgb565_t'(r * 2048 + g * 32 + b);
    endfunction

    function automatic expOut_t refOutput(int h, int v, logic patMode);
        expOut_t e;
        e.active = (h < HActive) && (v < VActive);
        e.vBlank = (v >= VActive);
        e.hSync  = (h >= HActive + HFront) && (h < HActive + HFront + HSyncLen);
        e.vSync  = (v >= VActive + VFront) && (v < VActive + VFront + VSyncLen);
        if (!e.active) begin
            e.colour = '0;
        end else if (patMode) begin
            e.colour = patternColour(h, v);
        end else begin
            e.colour = extTable[v * LineLen + h];
        end
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: actual 0x%0h expected 0x%0h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic waitForReset(input int maxCycles);
        int count;
        count = 0;
        while (!arstN && count < maxCycles) begin
            @(negedge vidClk);
            count++;
        end
        if (!arstN) begin
            $display("Timeout: reset was not released within %0d cycles", maxCycles);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    // Returns at the falling edge of the cycle that shows (h,v)
    task automatic waitForPos(input int h, input int v, input int maxCycles);
        int count;
        if (timedOut) return;
        count = 1;
        @(negedge vidClk);
        while (!(int'(nextHPos) == h && int'(nextVPos) == v) && count < maxCycles) begin
            @(negedge vidClk);
            count++;
        end
        if (!(int'(nextHPos) == h && int'(nextVPos) == v)) begin
            $display("Timeout: position (%0d,%0d) not reached within %0d cycles", h, v,
                     maxCycles);
            timeoutCount++;
            timedOut = 1'b1;
        end
    endtask

    // Colour for the position seen in the previous cycle
    always @(posedge vidClk) begin
        colourIn <= extTable[colourIdx];
    end

    // Forwarded pixel clock, sampled in the middle of each video clock phase
    always @(vidClk) begin
        #25;
        checkValue("o_pixelClk", 32'(pixelClk), 32'(!vidClk));
    end

    always @(negedge vidClk) begin : compareOutputs
        expOut_t phaseExp;
        expOut_t pinExp;
        if (!arstN) begin
            histValid = 0;
            expH = 0;
            expV = 0;
        end
        phaseExp = (histValid >= 1) ? refOutput(histH[0], histV[0], histMode[0]) : '0;
        pinExp   = (histValid >= 2) ? refOutput(histH[1], histV[1], histMode[1]) : '0;
        checkValue("o_nextHPos", 32'(nextHPos), expH);
        checkValue("o_nextVPos", 32'(nextVPos), expV);
        checkValue("o_inActiveArea", 32'(inActiveArea), 32'(phaseExp.active));
        checkValue("o_inVBlank", 32'(inVBlank), 32'(phaseExp.vBlank));
        checkValue("o_hSync", 32'(hSyncPin), 32'(pinExp.hSync));
        checkValue("o_vSync", 32'(vSyncPin), 32'(pinExp.vSync));
        checkValue("o_nBlank", 32'(nBlank), 32'(pinExp.active));
        checkValue("o_r", 32'(red), 32'(pinExp.colour[15:11]));
        checkValue("o_g", 32'(green), 32'(pinExp.colour[10:5]));
        checkValue("o_b", 32'(blue), 32'(pinExp.colour[4:0]));
        if (arstN) begin
            histH[1] = histH[0];
            histV[1] = histV[0];
            histMode[1] = histMode[0];
            histH[0] = expH;
            histV[0] = expV;
            histMode[0] = patternEn;  // Mode held while this position is shown
            colourIdx = (int'(nextVPos) * LineLen + int'(nextHPos)) % TableSize;
            if (histValid < 2) histValid++;
            if (expH == LineLen - 1) begin
                expH = 0;
                expV = (expV == FrameLen - 1) ? 0 : expV + 1;
            end else begin
                expH++;
            end
        end
    end

    initial begin : stimulus
        int i;
        patternEn = 1'b0;
        for (i = 0; i < TableSize; i++) begin
            extTable[i] = rgb565_t'($random(seed));
        end
        waitForReset(10);
        waitForPos(LineLen - 1, FrameLen - 1, FrameWait);  // Two external frames
        waitForPos(LineLen - 1, FrameLen - 1, FrameWait);
        @(posedge vidClk);
        patternEn <= 1'b1;                                  // Whole pattern frame
        waitForPos(LineLen - 1, FrameLen - 1, FrameWait);
        waitForPos(5, 2, FrameWait);
        @(posedge vidClk);
        patternEn <= 1'b0;  // Back to external mid-line
        waitForPos(9, 4, FrameWait);
        @(posedge vidClk);
        patternEn <= 1'b1;
        waitForPos(LineLen - 1, FrameLen - 1, FrameWait);
        waitForPos(3, 0, LineLen);  // Let the pipeline drain
        @(posedge vidClk);
        $display("Summary: %0d value mismatches, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
vidPkg.sv
vidRasterCounter.sv
vidPhaseFsm.sv
vidPatternSource.sv
vidDacOutput.sv
adv7123Video.sv
tb_vidClkGen.sv
tb_adv7123Video.sv

// ==== Makefile ====
TOP := tb_adv7123Video
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 -f all.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)
	verilator --lint-only vidPkg.sv vidRasterCounter.sv vidPhaseFsm.sv \
		vidPatternSource.sv vidDacOutput.sv adv7123Video.sv --top-module adv7123Video

clean:
	rm -rf obj_dir $(LOG)
